//--- cin_rx.f
+incdir+source
source/cin_reg_pkg.sv
source/cin_lane_pkg.sv
source/cin_reg_decode.sv
source/cin_lane.sv
source/cin_readback.sv
source/cin_rx_top.sv
verification/cin_rx_chk.sv
verification/cin_rx_tb.sv

//--- Makefile
TOP = cin_rx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f cin_rx.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q -e "Test failures found" -e "%Error" sim.log; then \
		echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "simulation incomplete"; exit 1)

lint:
	verilator --lint-only --timing --assert -f cin_rx.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- verification/cin_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_rx_tb
    import cin_reg_pkg::*, cin_lane_pkg::*;
();

    // five tests with margin, 8 ns per cycle
    localparam int WATCHDOG_CYCLES = 20000;
    localparam int N_WORDS = 4;

    logic cin_clk_i;
    logic rst;
    logic [`CIN_NUM_LANES*`CIN_NIBBLE_W-1:0] lane_data;
    logic reg_wr;
    logic reg_rd;
    reg_adr_t reg_adr;
    word_t reg_wdat;
    word_t reg_rdat;
    logic reg_rvalid;
    logic [`CIN_NUM_LANES*`CIN_WORD_W-1:0] cin_response;
    logic [`CIN_NUM_LANES-1:0] cin_valid;
    // mirror of the lane nibble counter
    slip_t lane_cnt;
    integer seed;
    int errors;
    int test_err0;
    int tests_run;
    int tests_failed;

    cin_rx_top DUT (
        .cin_clk_i(cin_clk_i), .rst(rst), .lane_data_i(lane_data),
        .reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_adr_i(reg_adr),
        .reg_wdat_i(reg_wdat), .reg_rdat_o(reg_rdat), .reg_rvalid_o(reg_rvalid),
        .cin_response_o(cin_response), .cin_valid_o(cin_valid)
    );

    bind cin_rx_top cin_rx_chk u_chk (
        .cin_clk_i(cin_clk_i), .rst(rst), .reg_rd_i(reg_rd_i),
        .reg_rvalid_o(reg_rvalid_o), .cin_valid_o(cin_valid_o),
        .wr_slip_i(wr_slip), .ctrl_vals_i(ctrl_vals)
    );

    initial begin
        cin_clk_i = 1'b0;
        forever #4 cin_clk_i = ~cin_clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge cin_clk_i);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    // nibble idx of the training word, idx 0 is sent first
    function automatic nibble_t train_nibble(input int idx);
        word_t w;
        w = `CIN_TRAIN_VALUE;
        return w[31-4*idx -: 4];
    endfunction

    always @(posedge cin_clk_i) begin
        lane_cnt <= rst ? slip_t'(0) : lane_cnt + 1'b1;
    end

    // lane i is i nibbles ahead, word ends on counter value (8-i) mod 8
    always @(negedge cin_clk_i) begin
        for (int i = 0; i < `CIN_NUM_LANES; i++) begin
            lane_data[i*4 +: 4] <= train_nibble((int'(lane_cnt) + i + 7) % 8);
        end
    end

    function automatic reg_adr_t make_adr(input int lane, input reg_sel_t sel);
        reg_adr_t a;
        a.lane = lane_idx_t'(lane);
        a.sel = sel;
        return a;
    endfunction

    task automatic reg_write(input reg_adr_t adr, input word_t dat);
        @(negedge cin_clk_i);
        reg_wr = 1'b1;
        reg_adr = adr;
        reg_wdat = dat;
        @(negedge cin_clk_i);
        reg_wr = 1'b0;
        repeat (2) @(negedge cin_clk_i);
    endtask

    task automatic reg_read(input reg_adr_t adr, output word_t dat);
        int waited;
        @(negedge cin_clk_i);
        reg_rd = 1'b1;
        reg_adr = adr;
        @(negedge cin_clk_i);
        reg_rd = 1'b0;
        waited = 0;
        while (!reg_rvalid && waited < 8) begin
            @(negedge cin_clk_i);
            waited++;
        end
        if (!reg_rvalid) begin
            $display("read of lane %0d reg %0d got no response", adr.lane, adr.sel);
            errors++;
        end
        dat = reg_rdat;
    endtask

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic slip_lane(input int lane, input int n);
        repeat (n) reg_write(make_adr(lane, REG_SLIP), '0);
    endtask

    // value checks here plus assertion failures in the bound checker
    task automatic test_done(input string name);
        int failed_now;
        failed_now = errors + DUT.u_chk.fail_count;
        tests_run++;
        if (failed_now != test_err0) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, failed_now - test_err0);
        end else begin
            $display("test %s: PASS", name);
        end
        test_err0 = failed_now;
    endtask

    initial begin
        word_t rd;
        word_t v;
        int n;
        int waited;
        seed = 32'h631dd07b;
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_adr = '0;
        reg_wdat = '0;
        lane_data = '0;
        errors = 0;
        test_err0 = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge cin_clk_i);
        @(negedge cin_clk_i);
        rst = 1'b0;
        @(negedge cin_clk_i);
        check_val("cin_valid_o", word_t'(cin_valid), '0);
        check_val("reg_rvalid_o", word_t'(reg_rvalid), '0);
        test_done("reset");

        // the latency itself is asserted in the checker
        for (int i = 0; i < `CIN_NUM_LANES; i++) begin
            reg_read(make_adr(i, REG_ERRCNT), rd);
            check_val("errcnt", rd, '0);
        end
        test_done("read latency");

        // random enable and training bits, slip phase still zero
        for (int i = 0; i < `CIN_NUM_LANES; i++) begin
            v = $random(seed);
            v = v & 32'h3;
            reg_write(make_adr(i, REG_CTRL), v);
            reg_read(make_adr(i, REG_CTRL), rd);
            check_val("ctrl", rd, v);
        end
        repeat (40) @(negedge cin_clk_i);
        test_done("ctrl and enable");

        for (int i = 0; i < `CIN_NUM_LANES; i++) begin
            n = (8 - i) % 8;
            reg_write(make_adr(i, REG_CTRL), 32'h1);
            slip_lane(i, n);
            reg_read(make_adr(i, REG_CTRL), rd);
            check_val("ctrl slip", rd, (word_t'(n % 8) << CTRL_SLIP_LSB) | 32'h1);
            // slip register is write-only even with a nonzero phase
            reg_read(make_adr(i, REG_SLIP), rd);
            check_val("slip readback", rd, '0);
            repeat (24) @(negedge cin_clk_i);
            reg_read(make_adr(i, REG_CAPTURE), rd);
            check_val("capture", rd, `CIN_TRAIN_VALUE);
            for (int k = 0; k < 3; k++) begin
                waited = 0;
                @(negedge cin_clk_i);
                while (!cin_valid[i] && waited < 20) begin
                    @(negedge cin_clk_i);
                    waited++;
                end
                if (!cin_valid[i]) begin
                    $display("lane %0d emitted no word", i);
                    errors++;
                end
                check_val("cin_response_o", cin_response[i*32 +: 32], `CIN_TRAIN_VALUE);
            end
        end
        test_done("slip and capture");

        // one extra slip misaligns, seven more restore alignment
        for (int i = 0; i < `CIN_NUM_LANES; i++) begin
            slip_lane(i, 1);
            reg_write(make_adr(i, REG_CTRL), 32'h3);
            reg_write(make_adr(i, REG_INTERVAL), N_WORDS);
            repeat ((N_WORDS + 2) * 8) @(negedge cin_clk_i);
            reg_read(make_adr(i, REG_ERRCNT), rd);
            check_val("errcnt misaligned", rd, N_WORDS);
            // interval register is write-only while loaded
            reg_read(make_adr(i, REG_INTERVAL), rd);
            check_val("interval readback", rd, '0);
            slip_lane(i, 7);
            reg_write(make_adr(i, REG_INTERVAL), N_WORDS);
            repeat ((N_WORDS + 2) * 8) @(negedge cin_clk_i);
            reg_read(make_adr(i, REG_ERRCNT), rd);
            check_val("errcnt aligned", rd, '0);
        end
        test_done("error counting");

        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
            tests_run, tests_failed, errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cin_rx_chk.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_rx_chk
    import cin_reg_pkg::*;
(
    input wire logic                      cin_clk_i,
    input wire logic                      rst,
    input wire logic                      reg_rd_i,
    input wire logic                      reg_rvalid_o,
    input wire logic [`CIN_NUM_LANES-1:0] cin_valid_o,
    input wire logic [`CIN_NUM_LANES-1:0] wr_slip_i,
    input wire logic [6:0]                ctrl_vals_i [`CIN_NUM_LANES]
);

    // assertion failures so far, also read by the testbench
    int fail_count = 0;

    // outputs quiet during reset and on the first cycle after it
    a_reset_quiet: assert property (@(posedge cin_clk_i)
        $past(rst) |-> (cin_valid_o == '0 && !reg_rvalid_o))
        else begin
            $error("outputs active in reset");
            fail_count++;
        end

    // read response exactly two cycles after the read strobe
    a_read_latency: assert property (@(posedge cin_clk_i) disable iff (rst)
        reg_rvalid_o == $past(reg_rd_i, 2))
        else begin
            $error("read response latency");
            fail_count++;
        end

    for (genvar i = 0; i < `CIN_NUM_LANES; i++) begin : g_lane_chk
        // cycles in a row with the lane enabled and no slip strobe
        int quiet;

        always_ff @(posedge cin_clk_i) begin
            if (rst || wr_slip_i[i] || !ctrl_vals_i[i][CTRL_EN_BIT]) begin
                quiet <= 0;
            end else if (quiet < 16) begin
                quiet <= quiet + 1;
            end
        end

        a_enable_gate: assert property (@(posedge cin_clk_i) disable iff (rst)
            cin_valid_o[i] |-> $past(ctrl_vals_i[i][CTRL_EN_BIT]))
            else begin
                $error("valid from a disabled lane");
                fail_count++;
            end

        // word cadence is fixed at eight nibbles once slips settle
        a_word_spacing: assert property (@(posedge cin_clk_i) disable iff (rst)
            quiet >= 10 |-> cin_valid_o[i] == $past(cin_valid_o[i], 8))
            else begin
                $error("valid spacing not eight cycles");
                fail_count++;
            end
    end

endmodule

`default_nettype wire

//--- source/cin_rx_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_rx_top
    import cin_reg_pkg::*, cin_lane_pkg::*;
(
    input  wire logic                                    cin_clk_i,
    input  wire logic                                    rst,
    // one nibble per lane, lane i in field i
    input  wire logic [`CIN_NUM_LANES*`CIN_NIBBLE_W-1:0] lane_data_i,
    // register port
    input  wire logic                                    reg_wr_i,
    input  wire logic                                    reg_rd_i,
    input  wire reg_adr_t                                reg_adr_i,
    input  wire word_t                                   reg_wdat_i,
    output word_t                                        reg_rdat_o,
    output logic                                         reg_rvalid_o,
    // lane word outputs
    output logic [`CIN_NUM_LANES*`CIN_WORD_W-1:0]        cin_response_o,
    output logic [`CIN_NUM_LANES-1:0]                    cin_valid_o
);

    // decoded commands
    logic [`CIN_NUM_LANES-1:0] wr_ctrl;
    logic [`CIN_NUM_LANES-1:0] wr_slip;
    logic [`CIN_NUM_LANES-1:0] wr_interval;
    logic rd_stb;
    lane_idx_t rd_lane;
    reg_sel_t rd_sel;
    word_t cmd_wdat;

    // per-lane readback sources
    word_t capture_words [`CIN_NUM_LANES];
    ctrl_rb_t ctrl_vals [`CIN_NUM_LANES];
    errcnt_t errcnts [`CIN_NUM_LANES];

    cin_reg_decode u_decode (
        .cin_clk_i     (cin_clk_i),
        .rst           (rst),
        .reg_wr_i      (reg_wr_i),
        .reg_rd_i      (reg_rd_i),
        .reg_adr_i     (reg_adr_i),
        .reg_wdat_i    (reg_wdat_i),
        .wr_ctrl_o     (wr_ctrl),
        .wr_slip_o     (wr_slip),
        .wr_interval_o (wr_interval),
        .rd_stb_o      (rd_stb),
        .rd_lane_o     (rd_lane),
        .rd_sel_o      (rd_sel),
        .cmd_wdat_o    (cmd_wdat)
    );

    for (genvar i = 0; i < `CIN_NUM_LANES; i++) begin : g_lane
        cin_lane u_lane (
            .cin_clk_i      (cin_clk_i),
            .rst            (rst),
            .nibble_i       (lane_data_i[i*`CIN_NIBBLE_W +: `CIN_NIBBLE_W]),
            .wr_ctrl_i      (wr_ctrl[i]),
            .wr_slip_i      (wr_slip[i]),
            .wr_interval_i  (wr_interval[i]),
            .cmd_wdat_i     (cmd_wdat),
            .word_o         (cin_response_o[i*`CIN_WORD_W +: `CIN_WORD_W]),
            .word_valid_o   (cin_valid_o[i]),
            .capture_word_o (capture_words[i]),
            .ctrl_o         (ctrl_vals[i]),
            .errcnt_o       (errcnts[i])
        );
    end

    cin_readback u_readback (
        .cin_clk_i       (cin_clk_i),
        .rst             (rst),
        .rd_stb_i        (rd_stb),
        .rd_lane_i       (rd_lane),
        .rd_sel_i        (rd_sel),
        .capture_words_i (capture_words),
        .ctrl_i          (ctrl_vals),
        .errcnt_i        (errcnts),
        .reg_rdat_o      (reg_rdat_o),
        .reg_rvalid_o    (reg_rvalid_o)
    );

endmodule

`default_nettype wire

//--- source/cin_readback.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_readback
    import cin_reg_pkg::*, cin_lane_pkg::*;
(
    input  wire logic      cin_clk_i,
    input  wire logic      rst,
    input  wire logic      rd_stb_i,
    input  wire lane_idx_t rd_lane_i,
    input  wire reg_sel_t  rd_sel_i,
    input  wire word_t     capture_words_i [`CIN_NUM_LANES],
    input  wire ctrl_rb_t  ctrl_i [`CIN_NUM_LANES],
    input  wire errcnt_t   errcnt_i [`CIN_NUM_LANES],
    output word_t          reg_rdat_o,
    output logic           reg_rvalid_o
);

    // selected register, zero-extended to a full word
    word_t rd_word;

    always_comb begin
        case (rd_sel_i)
            REG_CTRL:
                rd_word = {{(`CIN_WORD_W-CTRL_RB_W){1'b0}}, ctrl_i[rd_lane_i]};
            REG_CAPTURE:
                rd_word = capture_words_i[rd_lane_i];
            REG_ERRCNT:
                rd_word = {{(`CIN_WORD_W-`CIN_ERRCNT_W){1'b0}}, errcnt_i[rd_lane_i]};
            // slip and interval are write-only
            default:
                rd_word = '0;
        endcase
    end

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= rd_stb_i;
        end
    end

    // read data holds until the next response
    always_ff @(posedge cin_clk_i) begin
        if (rd_stb_i) begin
            reg_rdat_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- source/cin_lane.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_lane
    import cin_reg_pkg::*, cin_lane_pkg::*;
(
    input  wire logic    cin_clk_i,
    input  wire logic    rst,
    input  wire nibble_t nibble_i,
    input  wire logic    wr_ctrl_i,
    input  wire logic    wr_slip_i,
    input  wire logic    wr_interval_i,
    input  wire word_t   cmd_wdat_i,
    output word_t        word_o,
    output logic         word_valid_o,
    output word_t        capture_word_o,
    output ctrl_rb_t     ctrl_o,
    output errcnt_t      errcnt_o
);

    // free-running nibble position and the slip phase it is compared to
    slip_t nib_cnt;
    slip_t slip;
    // slip request that landed on a word boundary
    logic slip_pend;
    logic slip_req;

    // control bits
    logic en;
    logic train;

    // the seven nibbles received before the current one
    logic [`CIN_WORD_W-`CIN_NIBBLE_W-1:0] shreg;
    word_t asm_word;

    logic word_done;
    logic emit;
    logic bit_err;

    // interval state
    interval_t interval;
    interval_t word_cnt;
    errcnt_t run_cnt;

    // first nibble of a word ends up in the top bits
    assign asm_word = {shreg, nibble_i};
    assign word_done = (nib_cnt == slip);
    assign emit = word_done && en;
    assign bit_err = train && (asm_word != `CIN_TRAIN_VALUE);

    // a slip applied on a boundary cycle would give a one-cycle word
    // so it waits one cycle in that case
    assign slip_req = wr_slip_i || slip_pend;

    always_comb begin
        ctrl_o = '0;
        ctrl_o[CTRL_EN_BIT] = en;
        ctrl_o[CTRL_TRAIN_BIT] = train;
        ctrl_o[CTRL_SLIP_LSB +: SLIP_W] = slip;
    end

    // word assembly, slip and control register
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            nib_cnt <= '0;
            slip <= '0;
            slip_pend <= 1'b0;
            en <= 1'b0;
            train <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            // wraps at eight nibbles
            nib_cnt <= nib_cnt + 1'b1;
            // each slip moves the boundary one nibble later
            if (slip_req && !word_done) begin
                slip <= slip + 1'b1;
            end
            slip_pend <= slip_req && word_done;
            if (wr_ctrl_i) begin
                en <= cmd_wdat_i[CTRL_EN_BIT];
                train <= cmd_wdat_i[CTRL_TRAIN_BIT];
            end
            word_valid_o <= emit;
        end
    end

    // shifter and word outputs
    always_ff @(posedge cin_clk_i) begin
        shreg <= asm_word[`CIN_WORD_W-`CIN_NIBBLE_W-1:0];
        if (word_done) begin
            word_o <= asm_word;
        end
        // capture keeps the last word actually sent out
        if (emit) begin
            capture_word_o <= asm_word;
        end
    end

    // training error counter over an interval of emitted words
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            interval <= '0;
            word_cnt <= '0;
            run_cnt <= '0;
            errcnt_o <= '0;
        end else if (wr_interval_i) begin
            // new interval restarts the count
            interval <= cmd_wdat_i[`CIN_INTERVAL_W-1:0];
            word_cnt <= '0;
            run_cnt <= '0;
        end else if (emit && interval != '0) begin
            if (word_cnt == interval - 1'b1) begin
                // interval done, publish including this word
                errcnt_o <= run_cnt + errcnt_t'(bit_err);
                run_cnt <= '0;
                word_cnt <= '0;
            end else begin
                run_cnt <= run_cnt + errcnt_t'(bit_err);
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cin_reg_decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "cin_cfg.svh"

module cin_reg_decode
    import cin_reg_pkg::*, cin_lane_pkg::*;
(
    input  wire logic                      cin_clk_i,
    input  wire logic                      rst,
    input  wire logic                      reg_wr_i,
    input  wire logic                      reg_rd_i,
    input  wire reg_adr_t                  reg_adr_i,
    input  wire word_t                     reg_wdat_i,
    output logic [`CIN_NUM_LANES-1:0]      wr_ctrl_o,
    output logic [`CIN_NUM_LANES-1:0]      wr_slip_o,
    output logic [`CIN_NUM_LANES-1:0]      wr_interval_o,
    output logic                           rd_stb_o,
    output lane_idx_t                      rd_lane_o,
    output reg_sel_t                       rd_sel_o,
    output word_t                          cmd_wdat_o
);

    // one-hot select of the addressed lane
    logic [`CIN_NUM_LANES-1:0] lane_hot;

    assign lane_hot = {{(`CIN_NUM_LANES-1){1'b0}}, 1'b1} << reg_adr_i.lane;

    // write strobes and read strobe, all one cycle behind the request
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            wr_ctrl_o <= '0;
            wr_slip_o <= '0;
            wr_interval_o <= '0;
            rd_stb_o <= 1'b0;
        end else begin
            // only writable registers get a strobe
            wr_ctrl_o <= (reg_wr_i && reg_adr_i.sel == REG_CTRL) ? lane_hot : '0;
            wr_slip_o <= (reg_wr_i && reg_adr_i.sel == REG_SLIP) ? lane_hot : '0;
            wr_interval_o <= (reg_wr_i && reg_adr_i.sel == REG_INTERVAL) ? lane_hot : '0;
            rd_stb_o <= reg_rd_i;
        end
    end

    // address and data are held from the last request
    always_ff @(posedge cin_clk_i) begin
        if (reg_rd_i) begin
            rd_lane_o <= reg_adr_i.lane;
            rd_sel_o <= reg_adr_i.sel;
        end
        // write data is broadcast to every lane
        if (reg_wr_i) begin
            cmd_wdat_o <= reg_wdat_i;
        end
    end

endmodule

`default_nettype wire

//--- source/cin_lane_pkg.sv
`default_nettype none
`include "cin_cfg.svh"

package cin_lane_pkg;

    // one deserialized nibble
    typedef logic [`CIN_NIBBLE_W-1:0] nibble_t;

    // assembled lane word
    typedef logic [`CIN_WORD_W-1:0] word_t;

    // nibble position inside a word, also the slip phase
    localparam int SLIP_W = $clog2(`CIN_NIBBLES_PER_WORD);
    typedef logic [SLIP_W-1:0] slip_t;

    // training error counts and the interval in words
    typedef logic [`CIN_ERRCNT_W-1:0] errcnt_t;
    typedef logic [`CIN_INTERVAL_W-1:0] interval_t;

    // low bits of REG_CTRL as read back
    // enable and training at the bottom, slip phase in 6:4
    localparam int CTRL_RB_W = 7;
    typedef logic [CTRL_RB_W-1:0] ctrl_rb_t;

endpackage

`default_nettype wire

//--- source/cin_reg_pkg.sv
`default_nettype none
`include "cin_cfg.svh"

package cin_reg_pkg;

    // address field widths
    localparam int LANE_W = $clog2(`CIN_NUM_LANES);
    localparam int SEL_W = `CIN_ADR_W - LANE_W;

    typedef logic [LANE_W-1:0] lane_idx_t;

    // registers within one lane
    typedef enum logic [SEL_W-1:0] {
        REG_CTRL     = 3'd0,
        REG_SLIP     = 3'd1,
        REG_CAPTURE  = 3'd2,
        REG_ERRCNT   = 3'd3,
        REG_INTERVAL = 3'd4
    } reg_sel_t;

    // lane in the upper bits, register in the lower bits
    typedef struct packed {
        lane_idx_t lane;
        reg_sel_t  sel;
    } reg_adr_t;

    // REG_CTRL bit positions
    localparam int CTRL_EN_BIT = 0;
    localparam int CTRL_TRAIN_BIT = 1;
    localparam int CTRL_SLIP_LSB = 4;

endpackage

`default_nettype wire

//--- source/cin_cfg.svh
`ifndef CIN_CFG_SVH
`define CIN_CFG_SVH

// lane count, seven cin bits plus cintio
`define CIN_NUM_LANES 8

// deserializer delivers one nibble per clock
`define CIN_NIBBLE_W 4
`define CIN_WORD_W 32
`define CIN_NIBBLES_PER_WORD 8

// register address is lane field over register field
`define CIN_ADR_W 6

// error counter is one bit wider than the interval so it cannot wrap
`define CIN_ERRCNT_W 25
`define CIN_INTERVAL_W 24

// training word sent by the far end while the link is trained
`define CIN_TRAIN_VALUE 32'hA55A6996

`endif
